//--- source/access_state_fsm.sv
`timescale 1ns/1ps

module access_state_fsm
(
    input  logic                          MCLK,
    input  logic                          rst_n,
    input  logic                          bss_s,     // active low, synced
    input  logic                          bsen_s,
    input  logic                          repen_s,
    input  logic                          swapen_s,
    output bubble_timing_pkg::access_type_t acc_type
);
    import bubble_timing_pkg::*;

    logic [3:0]   strobes;
    access_type_t acc_next;

    assign strobes = {bss_s, bsen_s, repen_s, swapen_s};

    //////////////////////////////////////////////////////////////////////
    // next state from the strobe tuple

    always_comb
    begin
        acc_next = acc_type;  // unknown tuples hold
        case (strobes)
            4'b1111:  // nothing asserted
            begin
                if (acc_type != STBY)
                begin
                    acc_next = RST;
                end
            end
            4'b0111:  // shift start
            begin
                if (acc_type == RST)
                begin
                    acc_next = STBY;
                end
            end
            4'b1011:  // shift enable, seek or load
            begin
                if (acc_type == STBY || acc_type == RST)
                begin
                    acc_next = IDLE;
                end
            end
            4'b1001:  // replicate pulse during shift
            begin
                if (acc_type == IDLE)
                begin
                    acc_next = USER;
                end
            end
            4'b1010:  // swap pulse during shift
            begin
                if (acc_type == IDLE)
                begin
                    acc_next = SWAP;
                end
            end
            default:
            begin
                acc_next = acc_type;
            end
        endcase
    end

    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
        begin
            acc_type <= RST;
        end
        else
        begin
            acc_type <= acc_next;
        end
    end

endmodule

//--- source/bubble_timing_pkg.sv
package bubble_timing_pkg;

    ////////////////////////////////////////////////////////////////////////
    // access modes

    // bit 2 set: field rotates
    typedef enum logic [2:0] {
        RST  = 3'b000,  // idle, field stopped
        STBY = 3'b001,  // shift start seen
        IDLE = 3'b100,  // field running, no transfer
        SWAP = 3'b101,  // page write through swap gate
        USER = 3'b111   // page read through replicator
    } access_type_t;

    typedef logic [9:0]  field_pos_t;   // MCLK ticks in one bubble cycle, 0 = stopped
    typedef logic [11:0] abs_page_t;    // loop position at the replicator
    typedef logic [12:0] cycle_num_t;   // serial bit number

    ////////////////////////////////////////////////////////////////////////
    // field positions in MCLK ticks

    localparam field_pos_t POS_BIN_FIRST  = 10'd88;   // first data-in strobe
    localparam field_pos_t POS_STOP_CHECK = 10'd208;  // -X, field may stop here
    localparam field_pos_t POS_BOUT       = 10'd326;  // -Y minus two ticks
    localparam field_pos_t POS_PLUS_Y     = 10'd568;  // +Y, end of cycle
    localparam field_pos_t POS_WRAP_TO    = 10'd89;   // 480 ticks per cycle

    // no valid bit on the output
    localparam cycle_num_t CYCLE_NONE = '1;

    // 48 MHz down to the 4 MHz controller clock
    localparam logic [3:0] DIV_PERIOD = 4'd12;

endpackage

//--- source/bubble_timing_top.sv
`timescale 1ns/1ps

module bubble_timing_top
#(
    parameter bubble_timing_pkg::abs_page_t  INIT_ABS_PAGE  = 12'd1951,
    parameter bubble_timing_pkg::abs_page_t  LOOP_POSITIONS = 12'd2053,
    parameter bubble_timing_pkg::cycle_num_t PROP_DELAY     = 13'd98,
    parameter bubble_timing_pkg::cycle_num_t PAGE_BITS      = 13'd584
)
(
    input  logic                            MCLK,
    input  logic                            rst_n,
    input  logic                            en_n,
    input  logic                            bss_n,
    input  logic                            bsen_n,
    input  logic                            repen_n,
    input  logic                            swapen_n,
    output logic                            clk_out,
    output bubble_timing_pkg::access_type_t acc_type,
    output bubble_timing_pkg::abs_page_t    abs_page,
    output bubble_timing_pkg::cycle_num_t   bout_cycle_num,
    output logic                            bin_clk_en_n,
    output logic                            bout_clk_en_n
);
    import bubble_timing_pkg::*;

    logic       bss_s;
    logic       bsen_s;
    logic       repen_s;
    logic       swapen_s;
    field_pos_t field_pos;  // shared by sequencer and tracker

    strobe_conditioner i_strobe_conditioner
    (
        .MCLK     (MCLK),
        .rst_n    (rst_n),
        .en_n     (en_n),
        .bss_n    (bss_n),
        .bsen_n   (bsen_n),
        .repen_n  (repen_n),
        .swapen_n (swapen_n),
        .clk_out  (clk_out),
        .bss_s    (bss_s),
        .bsen_s   (bsen_s),
        .repen_s  (repen_s),
        .swapen_s (swapen_s)
    );

    access_state_fsm i_access_state_fsm
    (
        .MCLK     (MCLK),
        .rst_n    (rst_n),
        .bss_s    (bss_s),
        .bsen_s   (bsen_s),
        .repen_s  (repen_s),
        .swapen_s (swapen_s),
        .acc_type (acc_type)
    );

    field_sequencer #(
        .INIT_ABS_PAGE  (INIT_ABS_PAGE),
        .LOOP_POSITIONS (LOOP_POSITIONS)
    ) i_field_sequencer (
        .MCLK          (MCLK),
        .rst_n         (rst_n),
        .acc_type      (acc_type),
        .field_pos     (field_pos),
        .abs_page      (abs_page),
        .bin_clk_en_n  (bin_clk_en_n),
        .bout_clk_en_n (bout_clk_en_n)
    );

    page_bit_tracker #(
        .PROP_DELAY (PROP_DELAY),
        .PAGE_BITS  (PAGE_BITS)
    ) i_page_bit_tracker (
        .MCLK           (MCLK),
        .rst_n          (rst_n),
        .acc_type       (acc_type),
        .field_pos      (field_pos),
        .bout_cycle_num (bout_cycle_num)
    );

endmodule

//--- source/field_sequencer.sv
`timescale 1ns/1ps

module field_sequencer
#(
    parameter bubble_timing_pkg::abs_page_t INIT_ABS_PAGE  = 12'd1951,
    parameter bubble_timing_pkg::abs_page_t LOOP_POSITIONS = 12'd2053
)
(
    input  logic                            MCLK,
    input  logic                            rst_n,
    input  bubble_timing_pkg::access_type_t acc_type,
    output bubble_timing_pkg::field_pos_t   field_pos,
    output bubble_timing_pkg::abs_page_t    abs_page,
    output logic                            bin_clk_en_n,   // sample write data
    output logic                            bout_clk_en_n   // launch read data
);
    import bubble_timing_pkg::*;

    logic rotating;

    assign rotating = acc_type[2];  // IDLE, USER, SWAP

    //////////////////////////////////////////////////////////////////////
    // rotating field position

    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
        begin
            field_pos <= '0;
        end
        else if (field_pos == '0)
        begin
            if (rotating)
            begin
                field_pos <= 10'd1;  // start of first cycle
            end
        end
        else if (field_pos == POS_STOP_CHECK && !rotating)
        begin
            field_pos <= '0;  // stop at -X only
        end
        else if (field_pos == POS_PLUS_Y)
        begin
            field_pos <= POS_WRAP_TO;
        end
        else
        begin
            field_pos <= field_pos + 10'd1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // absolute loop position, one step per +Y

    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
        begin
            abs_page <= INIT_ABS_PAGE;
        end
        else if (field_pos == POS_PLUS_Y)
        begin
            if (abs_page == LOOP_POSITIONS - 12'd1)
            begin
                abs_page <= '0;
            end
            else
            begin
                abs_page <= abs_page + 12'd1;
            end
        end
    end

    // data strobes, one tick after the matching position
    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
        begin
            bin_clk_en_n  <= 1'b1;
            bout_clk_en_n <= 1'b0;  // stopped field reads as position 0
        end
        else
        begin
            bin_clk_en_n  <= !(field_pos == POS_BIN_FIRST || field_pos == POS_PLUS_Y);
            bout_clk_en_n <= !(field_pos == '0 || field_pos == POS_BOUT);
        end
    end

endmodule

//--- source/page_bit_tracker.sv
`timescale 1ns/1ps

module page_bit_tracker
#(
    parameter bubble_timing_pkg::cycle_num_t PROP_DELAY = 13'd98,
    parameter bubble_timing_pkg::cycle_num_t PAGE_BITS  = 13'd584
)
(
    input  logic                            MCLK,
    input  logic                            rst_n,
    input  bubble_timing_pkg::access_type_t acc_type,
    input  bubble_timing_pkg::field_pos_t   field_pos,
    output bubble_timing_pkg::cycle_num_t   bout_cycle_num
);
    import bubble_timing_pkg::*;

    cycle_num_t prop_cnt;   // empty cycles seen so far
    cycle_num_t bit_cnt;    // next bit number to present
    logic       at_plus_y;
    logic       clear_rst;
    logic       prop_done;

    assign at_plus_y = (field_pos == POS_PLUS_Y);
    assign clear_rst = (field_pos == '0) && (acc_type == RST);
    assign prop_done = (prop_cnt == PROP_DELAY);

    //////////////////////////////////////////////////////////////////////
    // propagation delay, then page bits

    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
        begin
            prop_cnt       <= '0;
            bit_cnt        <= '0;
            bout_cycle_num <= CYCLE_NONE;
        end
        else if (clear_rst)
        begin
            prop_cnt       <= '0;
            bit_cnt        <= '0;
            bout_cycle_num <= CYCLE_NONE;
        end
        else if (at_plus_y)
        begin
            if (acc_type != USER)
            begin
                // idle or swap, nothing leaves the detector
                prop_cnt       <= '0;
                bit_cnt        <= '0;
                bout_cycle_num <= CYCLE_NONE;
            end
            else if (!prop_done)
            begin
                prop_cnt       <= prop_cnt + 13'd1;  // line still empty
                bout_cycle_num <= CYCLE_NONE;
            end
            else
            begin
                bout_cycle_num <= bit_cnt;
                if (bit_cnt != PAGE_BITS - 13'd1)
                begin
                    bit_cnt <= bit_cnt + 13'd1;
                end
                // last bit number held after the page ends
            end
        end
    end

endmodule

//--- source/strobe_conditioner.sv
`timescale 1ns/1ps

module strobe_conditioner
(
    input  logic MCLK,
    input  logic rst_n,
    input  logic en_n,      // high masks every strobe
    input  logic bss_n,     // shift start
    input  logic bsen_n,    // shift enable
    input  logic repen_n,   // replicator enable
    input  logic swapen_n,  // swap gate enable
    output logic clk_out,   // 4 MHz to the controller
    output logic bss_s,     // synced levels, still active low
    output logic bsen_s,
    output logic repen_s,
    output logic swapen_s
);
    import bubble_timing_pkg::*;

    logic [3:0] div_cnt;     // 0..11
    logic       sample_en;
    logic [3:0] strobe_raw;
    logic [3:0] sync_1;
    logic [3:0] sync_2;

    //////////////////////////////////////////////////////////////////////
    // divider, 6 ticks high / 6 ticks low

    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
        begin
            div_cnt <= '0;
            clk_out <= 1'b1;
        end
        else if (div_cnt == DIV_PERIOD - 4'd1)
        begin
            div_cnt <= '0;
            clk_out <= 1'b0;  // controller launches on this edge
        end
        else
        begin
            div_cnt <= div_cnt + 4'd1;
            if (div_cnt == (DIV_PERIOD >> 1) - 4'd1)
            begin
                clk_out <= 1'b1;
            end
        end
    end

    // counts 3, 7, 11 = falling phase of the 12 MHz reference
    assign sample_en = (div_cnt[1:0] == 2'b11);

    //////////////////////////////////////////////////////////////////////
    // mask, two-flop sync, then phase capture

    assign strobe_raw = {4{en_n}} | {bss_n, bsen_n, repen_n, swapen_n};

    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
        begin
            sync_1 <= '1;  // all inactive
            sync_2 <= '1;
            {bss_s, bsen_s, repen_s, swapen_s} <= '1;
        end
        else
        begin
            sync_1 <= strobe_raw;
            sync_2 <= sync_1;
            if (sample_en)
            begin
                {bss_s, bsen_s, repen_s, swapen_s} <= sync_2;
            end
        end
    end

endmodule

//--- test/bubble_timing_assert.sv
`timescale 1ns/1ps

module bubble_timing_assert
(
    input logic                            MCLK,
    input logic                            rst_n,
    input logic                            bin_clk_en_n,
    input bubble_timing_pkg::abs_page_t    abs_page,
    input bubble_timing_pkg::access_type_t acc_type
);
    import bubble_timing_pkg::*;

    logic any_failed = 1'b0;  // watched from the testbench

    // data-in strobe is a single tick
    bin_one_tick: assert property (@(posedge MCLK) disable iff (!rst_n)
        !bin_clk_en_n |=> bin_clk_en_n)
    else
    begin
        $error("bin_clk_en_n held low for two ticks");
        any_failed = 1'b1;
    end

    // loop position only steps together with a data-in strobe
    page_on_strobe: assert property (@(posedge MCLK) disable iff (!rst_n)
        (abs_page != $past(abs_page)) |-> !bin_clk_en_n)
    else
    begin
        $error("abs_page changed outside a bin_clk_en_n low tick");
        any_failed = 1'b1;
    end

    // USER is only reachable through IDLE
    no_rst_to_user: assert property (@(posedge MCLK) disable iff (!rst_n)
        (acc_type == USER) |-> ($past(acc_type) != RST))
    else
    begin
        $error("acc_type went from RST straight to USER");
        any_failed = 1'b1;
    end

endmodule

bind bubble_timing_top bubble_timing_assert i_bubble_timing_assert
(
    .MCLK         (MCLK),
    .rst_n        (rst_n),
    .bin_clk_en_n (bin_clk_en_n),
    .abs_page     (abs_page),
    .acc_type     (acc_type)
);

//--- test/tb_bubble_timing.sv
`timescale 1ns/1ps

module tb_bubble_timing;
    import bubble_timing_pkg::*;

    localparam int CLK_PERIOD     = 4;
    localparam int INIT_ABS_PAGE  = 1951;
    localparam int LOOP_POSITIONS = 2053;
    localparam int PROP_DELAY     = 98;
    localparam int PAGE_BITS      = 584;
    localparam int CYCLE_TICKS    = 480;  // one bubble cycle in MCLK
    localparam int CLK_HALF_TICKS = 6;    // clk_out high or low time
    localparam int GAP_PLUS_Y     = int'(POS_PLUS_Y) - int'(POS_BOUT);  // -Y to +Y strobe
    localparam int ROWS           = 9;
    localparam int ROW_WAIT       = 20;
    localparam int GAP_MAX        = 40;
    localparam int WATCHDOG_TICKS = 2 * (8 + ROWS * (ROW_WAIT + GAP_MAX)
                                    + (PROP_DELAY + PAGE_BITS + 10) * CYCLE_TICKS);

    logic         MCLK;
    logic         rst_n;
    logic         en_n;
    logic         bss_n;
    logic         bsen_n;
    logic         repen_n;
    logic         swapen_n;
    logic         clk_out;
    access_type_t acc_type;
    abs_page_t    abs_page;
    cycle_num_t   bout_cycle_num;
    logic         bin_clk_en_n;
    logic         bout_clk_en_n;

    // pins {en_n, bss_n, bsen_n, repen_n, swapen_n}, all active low
    logic [4:0]   row_pins [ROWS] = '{5'b01111, 5'b00111, 5'b01011, 5'b01001, 5'b01111,
                                      5'b00111, 5'b01011, 5'b01010, 5'b11010};
    access_type_t row_state [ROWS] = '{RST, STBY, IDLE, USER, RST, STBY, IDLE, SWAP, RST};

    int           bout_gap = 0;          // MCLK since last bout_clk_en_n low tick
    abs_page_t    exp_page;
    logic         page_wrapped = 1'b0;
    logic         clk_prev;
    int           clk_ticks;
    int           clk_edges;

    bubble_timing_top #(
        .INIT_ABS_PAGE  (INIT_ABS_PAGE),
        .LOOP_POSITIONS (LOOP_POSITIONS),
        .PROP_DELAY     (PROP_DELAY),
        .PAGE_BITS      (PAGE_BITS)
    ) i_bubble_timing_top (
        .MCLK           (MCLK),
        .rst_n          (rst_n),
        .en_n           (en_n),
        .bss_n          (bss_n),
        .bsen_n         (bsen_n),
        .repen_n        (repen_n),
        .swapen_n       (swapen_n),
        .clk_out        (clk_out),
        .acc_type       (acc_type),
        .abs_page       (abs_page),
        .bout_cycle_num (bout_cycle_num),
        .bin_clk_en_n   (bin_clk_en_n),
        .bout_clk_en_n  (bout_clk_en_n)
    );

    //////////////////////////////////////////////////////////////////////
    // error reporting and compare tasks

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_acc(input string name, input access_type_t got, input access_type_t exp);
        if (got !== exp)
            report_error($sformatf("FAILED %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_page(input string name, input abs_page_t got, input abs_page_t exp);
        if (got !== exp)
            report_error($sformatf("FAILED %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_cycle(input string name, input cycle_num_t got, input cycle_num_t exp);
        if (got !== exp)
            report_error($sformatf("FAILED %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_error($sformatf("FAILED %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_ticks(input string name, input int got, input int exp);
        if (got != exp)
            report_error($sformatf("FAILED %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    //////////////////////////////////////////////////////////////////////
    // waits on DUT strobes

    task automatic wait_state(input access_type_t exp);
        int waited;
        waited = 0;
        while (acc_type !== exp && waited < ROW_WAIT)
        begin
            @(posedge MCLK);
            waited++;
        end
        check_acc("acc_type", acc_type, exp);
    endtask

    task automatic wait_plus_y();
        do
        begin
            @(posedge MCLK);
        end
        while (!(bin_clk_en_n === 1'b0 && bout_gap == GAP_PLUS_Y));
    endtask

    task automatic count_to_bout(output int ticks);
        ticks = 0;
        do
        begin
            @(posedge MCLK);
            ticks++;
        end
        while (bout_clk_en_n !== 1'b0);
    endtask

    task automatic count_to_bin(output int ticks);
        ticks = 0;
        do
        begin
            @(posedge MCLK);
            ticks++;
        end
        while (bin_clk_en_n !== 1'b0);
    endtask

    // empty line first, then bit numbers, then hold at the last one
    task automatic run_user_phase();
        cycle_num_t exp_cyc;
        int         ticks;
        int         n;
        for (n = 1; n <= PROP_DELAY + PAGE_BITS + 3; n++)
        begin
            wait_plus_y();
            count_to_bout(ticks);  // read at -Y
            if (n <= PROP_DELAY)
                exp_cyc = '1;
            else if (n - PROP_DELAY - 1 < PAGE_BITS)
                exp_cyc = cycle_num_t'(n - PROP_DELAY - 1);
            else
                exp_cyc = cycle_num_t'(PAGE_BITS - 1);
            check_cycle("bout_cycle_num", bout_cycle_num, exp_cyc);
        end
    endtask

    task automatic run_swap_phase();
        int ticks;
        int k;
        wait_plus_y();         // first +Y in SWAP clears the output
        count_to_bout(ticks);  // align on -Y
        for (k = 0; k < 3; k++)
        begin
            check_cycle("bout_cycle_num", bout_cycle_num, '1);
            count_to_bout(ticks);
            check_ticks("bout_clk_en_n period", ticks, CYCLE_TICKS);
        end
        count_to_bin(ticks);   // align on +Y
        for (k = 0; k < 3; k++)
        begin
            count_to_bin(ticks);
            check_ticks("bin_clk_en_n period", ticks, CYCLE_TICKS);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // clock, monitors, watchdog

    initial
    begin
        MCLK = 1'b0;
        forever #(CLK_PERIOD / 2) MCLK = ~MCLK;
    end

    // loop position model, steps at every +Y strobe
    always @(posedge MCLK)
    begin
        if (!rst_n)
        begin
            exp_page = abs_page_t'(INIT_ABS_PAGE);
        end
        else if (bin_clk_en_n == 1'b0 && bout_gap != int'(POS_BIN_FIRST))
        begin
            if (exp_page == abs_page_t'(LOOP_POSITIONS - 1))
            begin
                exp_page     = '0;
                page_wrapped = 1'b1;
            end
            else
            begin
                exp_page = exp_page + 1'b1;
            end
            check_page("abs_page", abs_page, exp_page);
        end
        else if (bin_clk_en_n == 1'b0)
        begin
            check_page("abs_page", abs_page, exp_page);  // first strobe after start
        end
        bout_gap <= (bout_clk_en_n == 1'b0) ? 1 : bout_gap + 1;
    end

    // controller clock, every half period 6 MCLK
    always @(posedge MCLK)
    begin
        if (!rst_n)
        begin
            clk_prev  <= 1'b1;
            clk_ticks <= 0;
            clk_edges <= 0;
        end
        else if (clk_out != clk_prev)
        begin
            if (clk_edges > 0)  // first level after reset is longer
                check_ticks("clk_out half period", clk_ticks, CLK_HALF_TICKS);
            clk_edges <= clk_edges + 1;
            clk_ticks <= 1;
            clk_prev  <= clk_out;
        end
        else
        begin
            // level outlasting its half period, clock stuck
            if (clk_ticks >= ((clk_edges > 0) ? CLK_HALF_TICKS : 2 * CLK_HALF_TICKS))
                report_error("clk_out stopped toggling");
            clk_ticks <= clk_ticks + 1;
        end
    end

    always @(posedge MCLK)
    begin
        if (i_bubble_timing_top.i_bubble_timing_assert.any_failed === 1'b1)
            report_error("a bound assertion on bubble_timing_top failed");
    end

    initial
    begin
        #(WATCHDOG_TICKS * CLK_PERIOD);
        report_error("watchdog expired before the test sequence completed");
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus

    initial
    begin
        int seed_val;
        int gap_len;
        int r;
        seed_val = $urandom(8);
        rst_n    = 1'b0;
        en_n     = 1'b0;
        bss_n    = 1'b1;
        bsen_n   = 1'b1;
        repen_n  = 1'b1;
        swapen_n = 1'b1;
        repeat (8) @(posedge MCLK);
        rst_n <= 1'b1;
        @(posedge MCLK);

        // outputs straight out of reset
        check_bit("clk_out", clk_out, 1'b1);
        check_acc("acc_type", acc_type, RST);
        check_bit("bin_clk_en_n", bin_clk_en_n, 1'b1);
        check_bit("bout_clk_en_n", bout_clk_en_n, 1'b0);
        check_page("abs_page", abs_page, abs_page_t'(INIT_ABS_PAGE));
        check_cycle("bout_cycle_num", bout_cycle_num, '1);

        for (r = 0; r < ROWS; r++)
        begin
            @(posedge MCLK);
            {en_n, bss_n, bsen_n, repen_n, swapen_n} <= row_pins[r];
            wait_state(row_state[r]);
            if (row_state[r] == USER)
                run_user_phase();
            if (row_state[r] == SWAP)
                run_swap_phase();
            gap_len = $urandom % GAP_MAX + 1;  // idle gap between rows
            repeat (gap_len) @(posedge MCLK);
        end

        @(negedge MCLK);  // last edge settled, bound assertions included
        if (!page_wrapped)
        begin
            report_error("abs_page never wrapped to 0 during the run");
        end
        else if (i_bubble_timing_top.i_bubble_timing_assert.any_failed === 1'b1)
        begin
            report_error("a bound assertion on bubble_timing_top failed");
        end
        else
        begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

//--- vlog.f
source/bubble_timing_pkg.sv
source/strobe_conditioner.sv
source/access_state_fsm.sv
source/field_sequencer.sv
source/page_bit_tracker.sv
source/bubble_timing_top.sv
test/bubble_timing_assert.sv
test/tb_bubble_timing.sv
